/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vdec
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, look for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* cmd_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command FIFO, one write and up to two pops per cycle
// CQ_DEPTH must be a power of two, 2 or more
// a written entry reaches the head one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_queue import vdec_pkg::*; #(
  parameter int CQ_DEPTH = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  vdec_cmd_t in_cmd,
  output logic      in_ready,
  cmd_if.queue      cq
);

  localparam int AW = $clog2(CQ_DEPTH);
  localparam int CW = AW + 1;

  vdec_cmd_t     mem [CQ_DEPTH];
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  // committed entries, the ones the decoder sees
  logic [CW-1:0] count;
  // entry written last cycle, not committed yet
  logic          pend;
  logic [CW-1:0] used;
  logic          push;
  logic [1:0]    n_pop;

  assign used     = count + CW'(pend);
  assign in_ready = used != CW'(CQ_DEPTH);
  assign push     = in_valid && in_ready;
  // pops are contiguous, so a plain sum
  assign n_pop    = 2'(cq.pop[0]) + 2'(cq.pop[1]);

  // two oldest entries, pointer wraps by width
  assign cq.head[0] = mem[rd_ptr];
  assign cq.head[1] = mem[rd_ptr + AW'(1)];
  assign cq.empty   = count == '0;

  for (genvar k = 0; k < NUM_DE_INST; k++) begin : g_almost_empty
    assign cq.almost_empty[k] = count <= CW'(k);
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      pend   <= 1'b0;
    end else begin
      pend   <= push;
      wr_ptr <= wr_ptr + AW'(push);
      rd_ptr <= rd_ptr + AW'(n_pop);
      count  <= count + CW'(pend) - CW'(n_pop);
    end
  end

endmodule

/* sources.f */
+incdir+.
vdec_pkg.sv
vdec_if.sv
cmd_queue.sv
uop_queue.sv
vdec_unit.sv
vdec_ctrl.sv
vdec.sv
vdec_top.sv
tb_vdec.sv

/* tb_vdec_ref.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expected uop model and compare tasks for tb_vdec
// included inside the testbench module, uses its queue and counters
// model follows the decode rules only, not the queue timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_VDEC_REF_SVH
`define TB_VDEC_REF_SVH

// expands one command into its uops and appends them to exp_q
function automatic void ref_expand(input vdec_cmd_t cmd);
  logic [6:0] opc;
  bit         arith;
  bit         load;
  bit         mem;
  bit         indexed;
  int         n;
  int         e;
  int         lo;
  vdec_uop_t  u;
  opc   = cmd.inst.arith.opcode;
  arith = opc == 7'b1010111;
  load  = opc == 7'b0000111;
  mem   = load || opc == 7'b0100111;
  // group size, segments multiply it
  n = 1 << cmd.lmul;
  if (mem) n = n * (int'(cmd.inst.mem.nf) + 1);
  // bad encoding drops the whole command
  if (!(arith || mem) || n > MAX_UOP) return;
  indexed = mem && cmd.inst.mem.mop[0];
  e = VLENB >> cmd.sew;
  for (int k = 0; k < n; k++) begin
    lo = k * e;
    // every element of this uop lies before vstart
    if (lo + e - 1 < int'(cmd.vstart)) continue;
    u = '0;
    if (arith) u.op = OP_ARITH;
    else if (cmd.inst.mem.mop == 2'd0) u.op = load ? OP_LD_UNIT : OP_ST_UNIT;
    else if (cmd.inst.mem.mop == 2'd2) u.op = load ? OP_LD_STRIDED : OP_ST_STRIDED;
    else u.op = load ? OP_LD_INDEXED : OP_ST_INDEXED;
    u.vd        = 5'(int'(cmd.inst.arith.vd) + k);
    u.vs2       = (arith || indexed) ? 5'(int'(cmd.inst.arith.vs2) + k)
                                     : cmd.inst.mem.lumop_rs2;
    u.vs1_rs1   = arith ? 5'(int'(cmd.inst.arith.vs1) + k) : cmd.inst.mem.rs1;
    u.vm        = arith ? cmd.inst.arith.vm : cmd.inst.mem.vm;
    u.sew       = cmd.sew;
    u.uop_index = 3'(k);
    u.last      = k == n - 1;
    u.vstart    = (int'(cmd.vstart) > lo) ? 7'(int'(cmd.vstart) - lo) : 7'd0;
    exp_q.push_back(u);
  end
endfunction

task automatic compare_field(input string name, input int got, input int exp);
  if (got != exp) begin
    value_errs++;
    $display("Fail at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

// one output uop against the model
task automatic check_uop(input vdec_uop_t got, input vdec_uop_t exp);
  if (got.op != exp.op) begin
    value_errs++;
    $display("Fail at %0d ns: out_uop.op got %s expected %s", $time,
             got.op.name(), exp.op.name());
  end
  compare_field("out_uop.vd", got.vd, exp.vd);
  compare_field("out_uop.vs2", got.vs2, exp.vs2);
  compare_field("out_uop.vs1_rs1", got.vs1_rs1, exp.vs1_rs1);
  compare_field("out_uop.vm", got.vm, exp.vm);
  compare_field("out_uop.sew", got.sew, exp.sew);
  compare_field("out_uop.uop_index", got.uop_index, exp.uop_index);
  compare_field("out_uop.last", got.last, exp.last);
  compare_field("out_uop.vstart", got.vstart, exp.vstart);
endtask

// single-bit port against a fixed level
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    value_errs++;
    $display("Fail at %0d ns: %s got %b expected %b", $time, name, got, exp);
  end
endtask

// lost or surplus uops over the whole run
task automatic check_count(input int leftover, input int extra);
  if (leftover != 0) begin
    flow_errs++;
    $display("%0d expected uops never came out of the DUT", leftover);
  end
  if (extra != 0) begin
    flow_errs++;
    $display("%0d uops came out that no command asked for", extra);
  end
endtask

`endif

/* tb_vdec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for vdec_top at default queue depths
// fixed seed, directed cases first, then back-pressure and random mix
// outputs sampled on the rising edge, inputs driven on the falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_vdec import vdec_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_BP      = 40;
  localparam int NUM_RAND    = 147;
  // 13 directed commands on top
  localparam int NUM_CMDS    = 13 + NUM_BP + NUM_RAND;
  localparam int WATCHDOG_NS = NUM_CMDS * MAX_UOP * 4 * CLK_PERIOD + 100000;

  logic      clk;
  logic      reset;
  logic      in_valid;
  vdec_cmd_t in_cmd;
  logic      in_ready;
  logic      out_valid;
  vdec_uop_t out_uop;
  logic      out_ready;

  vdec_uop_t exp_q [$];
  int        value_errs;
  int        flow_errs;
  int        extra_outputs;
  int        stall_cycles;
  bit        saw_full;

  `include "tb_vdec_ref.svh"

  vdec_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_cmd    (in_cmd),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_uop   (out_uop),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random fields, then the opcode and sizes on top
  function automatic vdec_cmd_t build_cmd(input logic [6:0] opcode, input logic [1:0] sew,
                                          input logic [1:0] lmul, input logic [6:0] vstart);
    vdec_cmd_t c;
    c.inst              = vinst_u'($urandom);
    c.inst.arith.opcode = opcode;
    c.sew               = sew;
    c.lmul              = lmul;
    c.vstart            = vstart;
    return c;
  endfunction

  function automatic vdec_cmd_t random_cmd();
    logic [6:0]  opc;
    int unsigned sel;
    sel = $urandom % 8;
    if (sel < 3) opc = OPC_ARITH;
    else if (sel < 5) opc = OPC_LOAD;
    else if (sel < 7) opc = OPC_STORE;
    else opc = 7'($urandom);
    // vstart mostly zero
    return build_cmd(opc, 2'($urandom), 2'($urandom),
                     ($urandom % 4 == 0) ? 7'($urandom) : 7'd0);
  endfunction

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_cmd(input vdec_cmd_t c);
    bit accepted;
    accepted = 1'b0;
    in_valid = 1'b1;
    in_cmd   = c;
    while (!accepted) begin
      // in_ready only moves after a rising edge
      accepted = in_ready;
      if (!in_ready) saw_full = 1'b1;
      @(negedge clk);
    end
    ref_expand(c);
    in_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // out_ready, random or held low for stall_cycles
  initial begin
    forever begin
      @(negedge clk);
      if (stall_cycles > 0) begin
        stall_cycles--;
        out_ready = 1'b0;
      end else begin
        out_ready = ($urandom % 4) != 0;
      end
    end
  end

  // one expected uop per output handshake
  initial begin
    forever begin
      @(posedge clk);
      if (!reset && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          extra_outputs++;
          $display("uop index %0d came out at %0d ns with nothing expected",
                   out_uop.uop_index, $time);
        end else begin
          check_uop(out_uop, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    vdec_cmd_t c;
    void'($urandom(32'h88e9));
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_cmd        = '0;
    out_ready     = 1'b0;
    stall_cycles  = 0;
    value_errs    = 0;
    flow_errs     = 0;
    extra_outputs = 0;
    saw_full      = 1'b0;
    idle_cycles(4);
    reset = 1'b0;
    // idle after reset, nothing comes out
    repeat (4) begin
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("in_ready", in_ready, 1'b1);
      @(negedge clk);
    end
    // arithmetic split for each group size
    for (int l = 0; l < 4; l++) send_cmd(build_cmd(OPC_ARITH, 2'(l), 2'(l), 7'd0));
    // unknown opcode, then a 2 x 8 segment load
    send_cmd(build_cmd(7'b1111011, 2'd0, 2'd0, 7'd0));
    c = build_cmd(OPC_LOAD, 2'd1, 2'd1, 7'd0);
    c.inst.mem.nf = 3'd7;
    send_cmd(c);
    send_cmd(build_cmd(OPC_ARITH, 2'd0, 2'd1, 7'd0));
    // prestart, three uops gone, then a partial first uop
    send_cmd(build_cmd(OPC_ARITH, 2'd2, 2'd3, 7'd13));
    send_cmd(build_cmd(OPC_ARITH, 2'd0, 2'd1, 7'd5));
    // fault-first load
    c = build_cmd(OPC_LOAD, 2'd1, 2'd1, 7'd0);
    c.inst.mem.nf        = 3'd0;
    c.inst.mem.mop       = 2'd0;
    c.inst.mem.lumop_rs2 = 5'd16;
    send_cmd(c);
    // segment forms, strided load and indexed stores
    c = build_cmd(OPC_LOAD, 2'd2, 2'd2, 7'd0);
    c.inst.mem.nf  = 3'd1;
    c.inst.mem.mop = 2'd2;
    send_cmd(c);
    c = build_cmd(OPC_STORE, 2'd3, 2'd0, 7'd3);
    c.inst.mem.nf  = 3'd3;
    c.inst.mem.mop = 2'd1;
    send_cmd(c);
    c = build_cmd(OPC_STORE, 2'd0, 2'd1, 7'd0);
    c.inst.mem.nf  = 3'd2;
    c.inst.mem.mop = 2'd3;
    send_cmd(c);
    // long stall with back-to-back commands, both queues fill
    stall_cycles = 120;
    repeat (NUM_BP) send_cmd(random_cmd());
    // random mix with gaps and short stalls
    for (int i = 0; i < NUM_RAND; i++) begin
      if (i % 30 == 0) stall_cycles = 20 + $urandom % 20;
      send_cmd(random_cmd());
      if ($urandom % 4 == 0) idle_cycles($urandom % 4);
    end
    // drain, then a quiet window for strays
    for (int w = 0; w < 2000 && exp_q.size() != 0; w++) @(negedge clk);
    idle_cycles(20);
    check_count(exp_q.size(), extra_outputs);
    if (!saw_full) begin
      flow_errs++;
      $display("in_ready never went low while out_ready was held low");
    end
    $display("errors: %0d value, %0d flow", value_errs, flow_errs);
    if (value_errs == 0 && flow_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* uop_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uop FIFO, up to four writes and one read per cycle
// UQ_DEPTH must be a power of two, 4 or more
// writer must respect almost_full, no overflow check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uop_queue import vdec_pkg::*; #(
  parameter int UQ_DEPTH = 16
) (
  input  logic      clk,
  input  logic      reset,
  uop_if.queue      uq,
  output logic      out_valid,
  output vdec_uop_t out_uop,
  input  logic      out_ready
);

  localparam int AW = $clog2(UQ_DEPTH);
  localparam int CW = AW + 1;

  vdec_uop_t     mem [UQ_DEPTH];
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] free;
  logic [2:0]    n_push;
  logic          pop;

  // push lanes are packed low, count them
  always_comb begin
    n_push = '0;
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      n_push = n_push + 3'(uq.push[k]);
    end
  end

  assign free    = CW'(UQ_DEPTH) - count;
  assign uq.full = count == CW'(UQ_DEPTH);

  for (genvar k = 0; k < NUM_DE_UOP; k++) begin : g_almost_full
    assign uq.almost_full[k] = free <= CW'(k);
  end

  // read side straight from storage
  assign out_valid = count != '0;
  assign out_uop   = mem[rd_ptr];
  assign pop       = out_valid && out_ready;

  // lane k lands k slots past the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      if (uq.push[k]) begin
        mem[wr_ptr + AW'(k)] <= uq.data[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(n_push);
      rd_ptr <= rd_ptr + AW'(pop);
      count  <= count + CW'(n_push) - CW'(pop);
    end
  end

endmodule

/* vdec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decoder block between the command and uop queues
// decode path is combinational, only the resume index is a flop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vdec import vdec_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  cmd_if.decoder cq,
  uop_if.decoder uq
);

  logic [NUM_DE_INST-1:0]                      cmd_valid;
  logic [NUM_DE_INST-1:0][NUM_DE_UOP-1:0]      uop_valid;
  vdec_uop_t [NUM_DE_INST-1:0][NUM_DE_UOP-1:0] uop;
  logic [NUM_DE_INST-1:0][NUM_DE_UOP-1:0]      uop_last_pos;
  logic [UOP_INDEX_WIDTH-1:0]                  uop_index_remain;

  // head 1 valid needs two or more entries
  assign cmd_valid[0] = !cq.empty;
  assign cmd_valid[1] = !(|cq.almost_empty[1:0]);

  // oldest command, may resume mid-way
  vdec_unit u_unit0 (
    .cmd_valid        (cmd_valid[0]),
    .cmd              (cq.head[0]),
    .uop_index_remain (uop_index_remain),
    .uop_valid        (uop_valid[0]),
    .uop              (uop[0]),
    .uop_last_pos     (uop_last_pos[0])
  );

  // second command always from index 0
  vdec_unit u_unit1 (
    .cmd_valid        (cmd_valid[1]),
    .cmd              (cq.head[1]),
    .uop_index_remain ('0),
    .uop_valid        (uop_valid[1]),
    .uop              (uop[1]),
    .uop_last_pos     (uop_last_pos[1])
  );

  vdec_ctrl u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .cmd_valid        (cmd_valid),
    .uop_valid        (uop_valid),
    .uop              (uop),
    .uop_last_pos     (uop_last_pos),
    .uop_index_remain (uop_index_remain),
    .pop              (cq.pop),
    .uq               (uq)
  );

endmodule

/* vdec_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks decoded uops for the push lanes, makes pops
// command 1 goes out whole in one cycle or not at all
// resume index applies to command 0 only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vdec_ctrl import vdec_pkg::*; (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic [NUM_DE_INST-1:0]                       cmd_valid,
  input  logic [NUM_DE_INST-1:0][NUM_DE_UOP-1:0]       uop_valid,
  input  vdec_uop_t [NUM_DE_INST-1:0][NUM_DE_UOP-1:0]  uop,
  input  logic [NUM_DE_INST-1:0][NUM_DE_UOP-1:0]       uop_last_pos,
  output logic [UOP_INDEX_WIDTH-1:0]                   uop_index_remain,
  output logic [NUM_DE_INST-1:0]                       pop,
  uop_if.decoder                                       uq
);

  logic [NUM_DE_UOP-1:0]      lane_free;
  logic [NUM_DE_UOP-1:0]      push;
  vdec_uop_t [NUM_DE_UOP-1:0] data;
  // positions of command 0 consumed this cycle
  logic [UOP_INDEX_WIDTH-1:0] walked;

  // lane k usable when more than k slots are free
  for (genvar k = 0; k < NUM_DE_UOP; k++) begin : g_lane
    assign lane_free[k] = !uq.full && !uq.almost_full[k];
  end

  always_comb begin
    logic [2:0]                 slot;
    logic                       stop;
    logic                       done0;
    logic                       done1;
    logic [NUM_DE_UOP-1:0]      push1;
    vdec_uop_t [NUM_DE_UOP-1:0] data1;
    push   = '0;
    data   = '0;
    pop    = '0;
    walked = '0;
    slot   = '0;
    stop   = 1'b0;
    done0  = 1'b0;
    // command 0, stop at its last position or on a full lane
    for (int p = 0; p < NUM_DE_UOP; p++) begin
      if (cmd_valid[0] && !stop && !done0) begin
        if (uop_valid[0][p]) begin
          if (slot < 3'(NUM_DE_UOP) && lane_free[slot[1:0]]) begin
            data[slot[1:0]] = uop[0][p];
            push[slot[1:0]] = 1'b1;
            slot            = slot + 3'd1;
          end else begin
            stop = 1'b1;
          end
        end
        // dropped positions still advance
        if (!stop) begin
          walked = walked + 3'd1;
          done0  = uop_last_pos[0][p];
        end
      end
    end
    pop[0] = done0;
    // command 1 on a trial copy
    push1 = push;
    data1 = data;
    stop  = 1'b0;
    done1 = 1'b0;
    for (int p = 0; p < NUM_DE_UOP; p++) begin
      if (done0 && cmd_valid[1] && !stop && !done1) begin
        if (uop_valid[1][p]) begin
          if (slot < 3'(NUM_DE_UOP) && lane_free[slot[1:0]]) begin
            data1[slot[1:0]] = uop[1][p];
            push1[slot[1:0]] = 1'b1;
            slot             = slot + 3'd1;
          end else begin
            stop = 1'b1;
          end
        end
        if (!stop) done1 = uop_last_pos[1][p];
      end
    end
    // commit only a finished command 1
    if (done1) begin
      push   = push1;
      data   = data1;
      pop[1] = 1'b1;
    end
  end

  assign uq.push = push;
  assign uq.data = data;

  // any pop puts a fresh command at the head
  always_ff @(posedge clk) begin
    if (reset) begin
      uop_index_remain <= '0;
    end else if (|pop) begin
      uop_index_remain <= '0;
    end else begin
      uop_index_remain <= uop_index_remain + walked;
    end
  end

endmodule

/* vdec_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue-side links of the decoder
// pop and push vectors are contiguous from bit 0
// both take effect at the next clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

// command queue to decoder
interface cmd_if import vdec_pkg::*; ();
  // oldest first
  vdec_cmd_t [NUM_DE_INST-1:0] head;
  logic                        empty;
  // bit k: k or fewer entries held
  logic [NUM_DE_INST-1:0]      almost_empty;
  logic [NUM_DE_INST-1:0]      pop;

  modport queue (output head, output empty, output almost_empty, input pop);
  modport decoder (input head, input empty, input almost_empty, output pop);
endinterface

// decoder to uop queue
interface uop_if import vdec_pkg::*; ();
  logic [NUM_DE_UOP-1:0]      push;
  vdec_uop_t [NUM_DE_UOP-1:0] data;
  logic                       full;
  // bit k: k or fewer slots free
  logic [NUM_DE_UOP-1:0]      almost_full;

  modport queue (input push, input data, output full, output almost_full);
  modport decoder (output push, output data, input full, input almost_full);
endinterface

/* vdec_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes and types of the vector decode stage
// fixed at 2 commands and 4 uops per cycle, 8 uops per command
// VLENB of 16 bytes, lmul group sizes 1/2/4/8 only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vdec_pkg;

  // decoder width
  localparam int NUM_DE_INST     = 2;
  localparam int NUM_DE_UOP      = 4;
  localparam int MAX_UOP         = 8;
  localparam int UOP_INDEX_WIDTH = 3;
  // bytes per vector register
  localparam int VLENB           = 16;

  // major opcodes, anything else is a bad encoding
  localparam logic [6:0] OPC_ARITH = 7'b1010111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000111;
  localparam logic [6:0] OPC_STORE = 7'b0100111;

  // OP-V layout
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } varith_t;

  // LOAD-FP / STORE-FP layout, vd doubles as vs3 for stores
  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] lumop_rs2;
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] vd;
    logic [6:0] opcode;
  } vmem_t;

  // one instruction word, two views
  typedef union packed {
    varith_t arith;
    vmem_t   mem;
  } vinst_u;

  typedef struct packed {
    vinst_u     inst;
    logic [1:0] sew;
    logic [1:0] lmul;
    logic [6:0] vstart;
  } vdec_cmd_t;

  typedef enum logic [2:0] {
    OP_ARITH,
    OP_LD_UNIT,
    OP_LD_STRIDED,
    OP_LD_INDEXED,
    OP_ST_UNIT,
    OP_ST_STRIDED,
    OP_ST_INDEXED
  } vdec_op_e;

  typedef struct packed {
    vdec_op_e                   op;
    logic [4:0]                 vd;
    logic [4:0]                 vs2;
    logic [4:0]                 vs1_rs1;
    logic                       vm;
    logic [1:0]                 sew;
    logic [UOP_INDEX_WIDTH-1:0] uop_index;
    logic                       last;
    logic [6:0]                 vstart;
  } vdec_uop_t;

endpackage

/* vdec_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector decode stage, valid/ready on both sides
// depths are powers of two, uop queue at least 4
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vdec_top import vdec_pkg::*; #(
  parameter int CQ_DEPTH = 8,
  parameter int UQ_DEPTH = 16
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  vdec_cmd_t in_cmd,
  output logic      in_ready,
  output logic      out_valid,
  output vdec_uop_t out_uop,
  input  logic      out_ready
);

  cmd_if u_cmd_if ();
  uop_if u_uop_if ();

  cmd_queue #(
    .CQ_DEPTH (CQ_DEPTH)
  ) u_cmd_queue (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_cmd   (in_cmd),
    .in_ready (in_ready),
    .cq       (u_cmd_if.queue)
  );

  vdec u_vdec (
    .clk   (clk),
    .reset (reset),
    .cq    (u_cmd_if.decoder),
    .uq    (u_uop_if.decoder)
  );

  uop_queue #(
    .UQ_DEPTH (UQ_DEPTH)
  ) u_uop_queue (
    .clk       (clk),
    .reset     (reset),
    .uq        (u_uop_if.queue),
    .out_valid (out_valid),
    .out_uop   (out_uop),
    .out_ready (out_ready)
  );

endmodule

/* vdec_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decodes one command into four uop positions
// purely combinational, starts at uop_index_remain
// bad encodings give no uops, last position 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vdec_unit import vdec_pkg::*; (
  input  logic                       cmd_valid,
  input  vdec_cmd_t                  cmd,
  input  logic [UOP_INDEX_WIDTH-1:0] uop_index_remain,
  output logic [NUM_DE_UOP-1:0]      uop_valid,
  output vdec_uop_t [NUM_DE_UOP-1:0] uop,
  output logic [NUM_DE_UOP-1:0]      uop_last_pos
);

  logic                       is_arith;
  logic                       is_load;
  logic                       is_store;
  logic                       is_mem;
  logic                       is_indexed;
  logic [3:0]                 group;
  logic [6:0]                 total;
  logic                       inst_ok;
  logic [UOP_INDEX_WIDTH-1:0] last_index;
  logic [4:0]                 elem_per_uop;
  vdec_op_e                   op;

  assign is_arith   = cmd.inst.arith.opcode == OPC_ARITH;
  assign is_load    = cmd.inst.mem.opcode == OPC_LOAD;
  assign is_store   = cmd.inst.mem.opcode == OPC_STORE;
  assign is_mem     = is_load || is_store;
  // mop 1 and 3 are the indexed forms
  assign is_indexed = is_mem && cmd.inst.mem.mop[0];

  // uop count, segments multiply by nf+1
  assign group      = 4'd1 << cmd.lmul;
  assign total      = is_mem ? 7'(group) * (7'(cmd.inst.mem.nf) + 7'd1) : 7'(group);
  assign inst_ok    = cmd_valid && (is_arith || is_mem) && total <= 7'(MAX_UOP);
  assign last_index = UOP_INDEX_WIDTH'(total - 7'd1);
  assign elem_per_uop = 5'(VLENB >> cmd.sew);

  // lumop is ignored on mop 0, so fault-first decodes as unit-stride
  always_comb begin
    op = OP_ARITH;
    if (is_load) begin
      if (cmd.inst.mem.mop == 2'd0) op = OP_LD_UNIT;
      else if (cmd.inst.mem.mop == 2'd2) op = OP_LD_STRIDED;
      else op = OP_LD_INDEXED;
    end else if (is_store) begin
      if (cmd.inst.mem.mop == 2'd0) op = OP_ST_UNIT;
      else if (cmd.inst.mem.mop == 2'd2) op = OP_ST_STRIDED;
      else op = OP_ST_INDEXED;
    end
  end

  for (genvar p = 0; p < NUM_DE_UOP; p++) begin : g_pos
    logic [3:0] idx;
    // first element and one past the last
    logic [7:0] elem_lo;
    logic [7:0] elem_end;
    logic       in_range;
    logic       prestart;
    vdec_uop_t  u;

    assign idx      = 4'(uop_index_remain) + 4'(p);
    assign elem_lo  = 8'(idx[2:0]) * 8'(elem_per_uop);
    assign elem_end = elem_lo + 8'(elem_per_uop);
    assign in_range = idx <= 4'(last_index);
    // every element below vstart
    assign prestart = elem_end <= 8'(cmd.vstart);

    assign uop_valid[p]    = inst_ok && in_range && !prestart;
    assign uop_last_pos[p] = inst_ok ? (idx == 4'(last_index)) : (p == 0);

    always_comb begin
      u.op        = op;
      u.vd        = cmd.inst.arith.vd + 5'(idx[2:0]);
      u.vs2       = (is_arith || is_indexed) ? cmd.inst.arith.vs2 + 5'(idx[2:0])
                                             : cmd.inst.mem.lumop_rs2;
      u.vs1_rs1   = is_arith ? cmd.inst.arith.vs1 + 5'(idx[2:0]) : cmd.inst.mem.rs1;
      // vm sits at bit 25 in both views
      u.vm        = cmd.inst.arith.vm;
      u.sew       = cmd.sew;
      u.uop_index = idx[2:0];
      u.last      = idx == 4'(last_index);
      // vstart relative to this uop, floor at zero
      u.vstart    = (8'(cmd.vstart) > elem_lo) ? 7'(8'(cmd.vstart) - elem_lo) : 7'd0;
    end

    assign uop[p] = u;
  end

endmodule
